// ==== cmd_decoder.sv ====
`timescale 1ns/1ps
`include "nib_consts.svh"

module cmd_decoder
    import nib_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    rx_byte_if.dst       rx,
    reg_access_if.master acc,
    frame_status_if.src  st
);

    localparam logic [2:0] M_NONE  = 3'd0;  // no command byte yet
    localparam logic [2:0] M_SWR   = 3'd1;
    localparam logic [2:0] M_BURST = 3'd2;
    localparam logic [2:0] M_FULL  = 3'd3;  // count met, more is extra
    localparam logic [2:0] M_ILL   = 3'd4;

    logic [2:0]             mode;
    logic [2:0]             remain;
    logic [`NIB_REG_AW-1:0] ptr;
    cmd_word_u              cmd;

    assign cmd = rx.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode           <= M_NONE;
            acc.we         <= 1'b0;
            acc.re         <= 1'b0;
            st.done        <= 1'b0;
            st.err_illegal <= 1'b0;
            st.err_extra   <= 1'b0;
            st.err_short   <= 1'b0;
            st.err_empty   <= 1'b0;
        end else begin
            acc.we         <= 1'b0;
            acc.re         <= 1'b0;
            st.done        <= 1'b0;
            st.err_illegal <= 1'b0;
            st.err_extra   <= 1'b0;
            st.err_short   <= 1'b0;
            st.err_empty   <= 1'b0;
            if (rx.frame_end) begin
                st.done      <= 1'b1;
                st.err_empty <= (mode == M_NONE);
                st.err_short <= (mode == M_SWR) || (mode == M_BURST);
                mode         <= M_NONE;
            end else if (rx.valid && rx.first) begin
                case (cmd.single.op)
                    OP_WR_SINGLE: mode <= M_SWR;
                    OP_RD_SINGLE: begin
                        acc.re <= 1'b1;
                        mode   <= M_FULL;
                    end
                    OP_WR_BURST:  mode <= M_BURST;
                    default: begin
                        st.err_illegal <= 1'b1;
                        mode           <= M_ILL;  // rest of frame ignored
                    end
                endcase
            end else if (rx.valid) begin
                case (mode)
                    M_SWR: begin
                        acc.we <= 1'b1;
                        mode   <= M_FULL;
                    end
                    M_BURST: begin
                        acc.we <= 1'b1;
                        if (remain == 3'd0) mode <= M_FULL;
                    end
                    M_FULL:  st.err_extra <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // address and data path
    always_ff @(posedge clk) begin
        if (rx.valid && rx.first) begin
            acc.addr <= cmd.single.addr;
            if (cmd.burst.op == OP_WR_BURST) begin
                ptr    <= {cmd.burst.base, 3'b100};
                remain <= cmd.burst.len;
            end else begin
                ptr <= cmd.single.addr;
            end
        end else if (rx.valid) begin
            acc.addr  <= ptr;
            acc.wdata <= rx.data;
            if (mode == M_BURST) begin
                ptr    <= ptr + 1'b1;  // wraps within 0..63
                remain <= remain - 1'b1;
            end
        end
    end

    a_we_re_excl: assert property (@(posedge clk) disable iff (rst) !(acc.we && acc.re));

endmodule

// ==== flist.f ====
+incdir+.
nib_pkg.sv
nib_if.sv
nib_rx_framer.sv
cmd_decoder.sv
reg_exec.sv
resp_builder.sv
nib_link_top.sv
tb_nib_link.sv

// ==== nib_consts.svh ====
`ifndef NIB_CONSTS_SVH
`define NIB_CONSTS_SVH

// link framing bytes
`define NIB_PREAMBLE 8'h5A
`define NIB_SYNC     8'h0F

// register file address width, 64 entries
`define NIB_REG_AW   6

`endif

// ==== nib_if.sv ====
`timescale 1ns/1ps
`include "nib_consts.svh"

// payload bytes out of the framer
interface rx_byte_if;
    logic [7:0] data;
    logic       valid;
    logic       first;      // with valid on the command byte
    logic       frame_end;

    modport src (output data, valid, first, frame_end);
    modport dst (input data, valid, first, frame_end);
endinterface

interface reg_access_if;
    logic                   we;
    logic                   re;
    logic [`NIB_REG_AW-1:0] addr;
    logic [7:0]             wdata;

    modport master (output we, re, addr, wdata);
    modport slave (input we, re, addr, wdata);
endinterface

// one-cycle pulses per frame
interface frame_status_if;
    logic done;
    logic err_illegal;
    logic err_extra;
    logic err_short;
    logic err_empty;

    modport src (output done, err_illegal, err_extra, err_short, err_empty);
    modport dst (input done, err_illegal, err_extra, err_short, err_empty);
endinterface

// ==== nib_link_top.sv ====
`timescale 1ns/1ps

module nib_link_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       fire,
    input  logic [3:0] din,
    output logic [7:0] rd_data,
    output logic       rd_valid,
    output logic       frame_ok,
    output logic       frame_err
);

    logic [7:0] rdata;
    logic       rvalid;

    rx_byte_if      rx_bus ();
    reg_access_if   acc_bus ();
    frame_status_if st_bus ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // framer -> decoder -> register file -> response
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    nib_rx_framer u_framer (
        .clk  (clk),
        .rst  (rst),
        .fire (fire),
        .din  (din),
        .rx   (rx_bus.src)
    );

    cmd_decoder u_decoder (
        .clk (clk),
        .rst (rst),
        .rx  (rx_bus.dst),
        .acc (acc_bus.master),
        .st  (st_bus.src)
    );

    reg_exec u_exec (
        .clk    (clk),
        .rst    (rst),
        .acc    (acc_bus.slave),
        .rdata  (rdata),
        .rvalid (rvalid)
    );

    resp_builder u_resp (
        .clk       (clk),
        .rst       (rst),
        .st        (st_bus.dst),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .frame_ok  (frame_ok),
        .frame_err (frame_err)
    );

endmodule

// ==== nib_pkg.sv ====
`include "nib_consts.svh"

package nib_pkg;

    typedef enum logic [1:0] {
        OP_WR_SINGLE = 2'b00,
        OP_RD_SINGLE = 2'b01,
        OP_WR_BURST  = 2'b10,
        OP_ILLEGAL   = 2'b11
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e                op;
        logic [`NIB_REG_AW-1:0] addr;
    } cmd_single_t;

    // burst covers len+1 regs, starting at {base, 3'b100}
    // so the top bank runs past 63 and wraps to 0
    typedef struct packed {
        cmd_op_e    op;
        logic [2:0] len;
        logic [2:0] base;
    } cmd_burst_t;

    typedef union packed {
        cmd_single_t single;
        cmd_burst_t  burst;
    } cmd_word_u;

endpackage

// ==== nib_rx_framer.sv ====
`timescale 1ns/1ps
`include "nib_consts.svh"

module nib_rx_framer (
    input  logic       clk,
    input  logic       rst,
    input  logic       fire,
    input  logic [3:0] din,
    rx_byte_if.src     rx
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_HUNT    = 2'd1;
    localparam logic [1:0] ST_LOCK    = 2'd2;
    localparam logic [1:0] ST_PAYLOAD = 2'd3;

    logic [1:0] state;
    logic       ph;         // parity of the nibble now on din
    logic       lock_ph;
    logic       synced;     // 0F seen, bytes go out
    logic       started;

    logic [3:0] hi_even;    // high nibble, even alignment
    logic [3:0] hi_odd;     // high nibble, odd alignment
    logic [7:0] byte_even;
    logic [7:0] byte_odd;
    logic [7:0] cur_byte;
    logic       in_lock_ph;
    logic       take_byte;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // two byte assemblies, one per nibble phase
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (ph) begin
            hi_odd <= din;
        end else begin
            hi_even <= din;
        end
    end

    assign byte_even  = {hi_even, din};
    assign byte_odd   = {hi_odd, din};
    assign cur_byte   = ph ? byte_even : byte_odd;  // byte closing on this nibble
    assign in_lock_ph = (ph == lock_ph);
    assign take_byte  = fire && (state == ST_PAYLOAD) && synced && in_lock_ph;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            ph           <= 1'b0;
            lock_ph      <= 1'b0;
            synced       <= 1'b0;
            started      <= 1'b0;
            rx.valid     <= 1'b0;
            rx.first     <= 1'b0;
            rx.frame_end <= 1'b0;
        end else begin
            rx.valid     <= 1'b0;
            rx.first     <= 1'b0;
            rx.frame_end <= 1'b0;
            if (!fire) begin
                // drop before sync ends the frame silently
                rx.frame_end <= (state == ST_PAYLOAD) && synced;
                state        <= ST_IDLE;
                ph           <= 1'b0;
                synced       <= 1'b0;
                started      <= 1'b0;
            end else begin
                ph <= ~ph;
                case (state)
                    ST_IDLE: begin
                        state <= ST_HUNT;
                    end
                    ST_HUNT: begin
                        if (cur_byte == `NIB_PREAMBLE) begin
                            lock_ph <= ph;
                            state   <= ST_LOCK;
                        end
                    end
                    ST_LOCK: begin
                        if (in_lock_ph) begin
                            state <= (cur_byte == `NIB_PREAMBLE) ? ST_PAYLOAD : ST_HUNT;
                        end
                    end
                    default: begin
                        if (take_byte) begin
                            rx.valid <= 1'b1;
                            rx.first <= !started;
                            started  <= 1'b1;
                        end else if (in_lock_ph && cur_byte == `NIB_SYNC) begin
                            synced <= 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_byte) begin
            rx.data <= cur_byte;
        end
    end

    a_valid_in_payload: assert property (@(posedge clk) disable iff (rst)
        $rose(rx.valid) |-> $past(state) == ST_PAYLOAD);

endmodule

// ==== reg_exec.sv ====
`timescale 1ns/1ps
`include "nib_consts.svh"

module reg_exec (
    input  logic        clk,
    input  logic        rst,
    reg_access_if.slave acc,
    output logic [7:0]  rdata,
    output logic        rvalid
);

    localparam int DEPTH = 1 << `NIB_REG_AW;

    logic [7:0] regs [DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= 8'h00;
            end
            rvalid <= 1'b0;
        end else begin
            rvalid <= acc.re;
            if (acc.we) begin
                regs[acc.addr] <= acc.wdata;
            end
        end
    end

    // registered read, one cycle after re
    always_ff @(posedge clk) begin
        if (acc.re) begin
            rdata <= regs[acc.addr];
        end
    end

endmodule

// ==== resp_builder.sv ====
`timescale 1ns/1ps

module resp_builder (
    input  logic         clk,
    input  logic         rst,
    frame_status_if.dst  st,
    input  logic [7:0]   rdata,
    input  logic         rvalid,
    output logic [7:0]   rd_data,
    output logic         rd_valid,
    output logic         frame_ok,
    output logic         frame_err
);

    logic err_sticky;
    logic err_now;

    assign err_now = st.err_illegal | st.err_extra | st.err_short | st.err_empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            err_sticky <= 1'b0;
            rd_valid   <= 1'b0;
            frame_ok   <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            rd_valid  <= rvalid;
            frame_ok  <= st.done && !(err_sticky || err_now);
            frame_err <= st.done && (err_sticky || err_now);
            if (st.done) begin
                err_sticky <= 1'b0;  // next frame starts clean
            end else if (err_now) begin
                err_sticky <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid) rd_data <= rdata;
    end

    a_status_excl: assert property (@(posedge clk) disable iff (rst)
        !(frame_ok && frame_err));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module tb_nib_link

sim_out=$(./obj_dir/Vtb_nib_link)
echo "$sim_out"

if grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== tb_nib_link.sv ====
`timescale 1ns/1ps
`include "nib_consts.svh"

module tb_nib_link
    import nib_pkg::*;
();

    localparam int MAX_FRAMES   = 32;
    localparam int MAX_BYTES    = 8;
    localparam int WAIT_LIMIT   = 60;  // cycles allowed per wait
    localparam int QUIET_CYCLES = 24;

    typedef enum logic [1:0] {STAT_NONE, STAT_OK, STAT_ERR} frame_stat_e;

    logic       clk;
    logic       rst;
    logic       fire;
    logic [3:0] din;
    logic [7:0] rd_data;
    logic       rd_valid;
    logic       frame_ok;
    logic       frame_err;

    string       f_name [MAX_FRAMES];
    int          f_fill [MAX_FRAMES];  // filler nibbles before preamble
    bit          f_drop [MAX_FRAMES];  // fire drops inside preamble
    int          f_len  [MAX_FRAMES];
    logic [7:0]  f_data [MAX_FRAMES][MAX_BYTES];
    frame_stat_e f_exp  [MAX_FRAMES];
    int          n_frames;

    logic [7:0]  model_regs [1 << `NIB_REG_AW];
    logic [7:0]  rd_q [$];
    frame_stat_e st_q [$];
    integer      seed;
    int          errors;
    int          n_pass;
    int          n_fail;
    int          i;

    nib_link_top UUT (
        .clk       (clk),
        .rst       (rst),
        .fire      (fire),
        .din       (din),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid),
        .frame_ok  (frame_ok),
        .frame_err (frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // outputs are stable mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (rd_valid) rd_q.push_back(rd_data);
            if (frame_ok) st_q.push_back(STAT_OK);
            if (frame_err) st_q.push_back(STAT_ERR);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // frame table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [7:0] single_cmd(input cmd_op_e op,
                                              input logic [`NIB_REG_AW-1:0] addr);
        cmd_word_u w;
        w.single.op   = op;
        w.single.addr = addr;
        return w;
    endfunction

    function automatic logic [7:0] burst_cmd(input logic [2:0] len, input logic [2:0] base);
        cmd_word_u w;
        w.burst.op   = OP_WR_BURST;
        w.burst.len  = len;
        w.burst.base = base;
        return w;
    endfunction

    task automatic add_frame(input string name, input int fill, input bit drop,
                             input frame_stat_e exp);
        f_name[n_frames] = name;
        f_fill[n_frames] = fill;
        f_drop[n_frames] = drop;
        f_len[n_frames]  = 0;
        f_exp[n_frames]  = exp;
        n_frames++;
    endtask

    task automatic add_byte(input logic [7:0] b);
        f_data[n_frames-1][f_len[n_frames-1]] = b;
        f_len[n_frames-1]++;
    endtask

    task automatic add_rand_bytes(input int n);
        logic [31:0] rnd;
        int          k;
        for (k = 0; k < n; k++) begin
            rnd = $random(seed);
            add_byte(rnd[7:0]);
        end
    endtask

    task automatic add_read(input string name, input logic [`NIB_REG_AW-1:0] addr,
                            input int fill);
        add_frame(name, fill, 1'b0, STAT_OK);
        add_byte(single_cmd(OP_RD_SINGLE, addr));
    endtask

    task automatic build_table();
        int k;
        add_frame("wr_single", 0, 1'b0, STAT_OK);
        add_byte(single_cmd(OP_WR_SINGLE, 6'd5));
        add_byte(8'h3C);
        add_read("rd_single", 6'd5, 0);
        add_read("rd_fresh_0", 6'd0, 2);
        add_read("rd_fresh_63", 6'd63, 0);
        add_frame("wr_odd_phase", 1, 1'b0, STAT_OK);
        add_byte(single_cmd(OP_WR_SINGLE, 6'd10));
        add_byte(8'hC3);
        add_read("rd_odd_phase", 6'd10, 3);
        add_frame("burst_20", 0, 1'b0, STAT_OK);  // regs 20..23
        add_byte(burst_cmd(3'd3, 3'd2));
        add_rand_bytes(4);
        for (k = 0; k < 4; k++) begin
            add_read($sformatf("rd_burst_%0d", 20 + k), 6'(20 + k), 0);
        end
        add_frame("burst_wrap", 1, 1'b0, STAT_OK);  // regs 60..63, 0, 1
        add_byte(burst_cmd(3'd5, 3'd7));
        add_rand_bytes(6);
        for (k = 0; k < 6; k++) begin
            add_read($sformatf("rd_wrap_%0d", (60 + k) % 64), 6'((60 + k) % 64), 0);
        end
        add_frame("illegal_op", 0, 1'b0, STAT_ERR);
        add_byte(8'hC5);
        add_byte(8'h11);
        add_frame("extra_byte", 0, 1'b0, STAT_ERR);
        add_byte(single_cmd(OP_WR_SINGLE, 6'd6));
        add_byte(8'hAA);
        add_byte(8'hBB);
        add_read("rd_extra", 6'd6, 0);
        add_frame("burst_short", 0, 1'b0, STAT_ERR);  // 2 of 4 bytes, from 36
        add_byte(burst_cmd(3'd3, 3'd4));
        add_rand_bytes(2);
        for (k = 0; k < 3; k++) begin
            add_read($sformatf("rd_short_%0d", 36 + k), 6'(36 + k), 0);
        end
        add_frame("no_command", 0, 1'b0, STAT_ERR);
        add_frame("drop_preamble", 0, 1'b1, STAT_NONE);
        add_frame("wr_after_drop", 2, 1'b0, STAT_OK);
        add_byte(single_cmd(OP_WR_SINGLE, 6'd12));
        add_byte(8'h77);
        add_read("rd_after_drop", 6'd12, 0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model, driver and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic model_frame(input int idx, output bit has_rd, output logic [7:0] rd_exp);
        cmd_word_u              w;
        logic [`NIB_REG_AW-1:0] a;
        int                     k;
        has_rd = 1'b0;
        rd_exp = 8'h00;
        w      = f_data[idx][0];
        if (!f_drop[idx] && f_len[idx] > 0) begin
            case (w.single.op)
                OP_WR_SINGLE: begin
                    if (f_len[idx] > 1) model_regs[w.single.addr] = f_data[idx][1];
                end
                OP_RD_SINGLE: begin
                    has_rd = 1'b1;
                    rd_exp = model_regs[w.single.addr];
                end
                OP_WR_BURST: begin
                    a = {w.burst.base, 3'b100};
                    for (k = 1; k < f_len[idx] && k <= int'(w.burst.len) + 1; k++) begin
                        model_regs[a] = f_data[idx][k];
                        a = a + 1'b1;  // wraps at 63
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic drive_nibble(input logic [3:0] n);
        @(negedge clk);
        fire <= 1'b1;
        din  <= n;
    endtask

    task automatic drive_byte(input logic [7:0] b);
        drive_nibble(b[7:4]);
        drive_nibble(b[3:0]);
    endtask

    task automatic send_frame(input int idx);
        logic [7:0] pre;
        int         k;
        pre = `NIB_PREAMBLE;
        for (k = 0; k < f_fill[idx]; k++) drive_nibble(4'h0);
        drive_byte(pre);
        if (f_drop[idx]) begin
            drive_nibble(pre[7:4]);
        end else begin
            drive_byte(pre);
            drive_byte(`NIB_SYNC);
            for (k = 0; k < f_len[idx]; k++) drive_byte(f_data[idx][k]);
        end
        @(negedge clk);
        fire <= 1'b0;
        din  <= 4'h0;
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %02h, actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input frame_stat_e exp,
                                input frame_stat_e act);
        if (act != exp) begin
            $display("[ERROR] %s: expected %s, actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic run_frame(input int idx);
        bit         has_rd;
        logic [7:0] rd_exp;
        int         errs_before;
        int         k;
        errs_before = errors;
        if (st_q.size() != 0 || rd_q.size() != 0) begin
            $display("%s: stray status or read pulse before the frame started", f_name[idx]);
            errors++;
            st_q.delete();
            rd_q.delete();
        end
        model_frame(idx, has_rd, rd_exp);
        send_frame(idx);
        if (f_exp[idx] == STAT_NONE) begin
            for (k = 0; k < QUIET_CYCLES; k++) @(posedge clk);
            if (st_q.size() != 0 || rd_q.size() != 0) begin
                $display("%s: frame dropped before sync still gave a pulse", f_name[idx]);
                errors++;
            end
        end else begin
            for (k = 0; k < WAIT_LIMIT && st_q.size() == 0; k++) @(posedge clk);
            if (st_q.size() == 0) begin
                $display("%s: no frame status within %0d cycles", f_name[idx], WAIT_LIMIT);
                errors++;
            end else begin
                check_status(f_name[idx], f_exp[idx], st_q.pop_front());
            end
            if (has_rd) begin
                for (k = 0; k < WAIT_LIMIT && rd_q.size() == 0; k++) @(posedge clk);
                if (rd_q.size() == 0) begin
                    $display("%s: no read data within %0d cycles", f_name[idx], WAIT_LIMIT);
                    errors++;
                end else begin
                    check_byte(f_name[idx], rd_exp, rd_q.pop_front());
                end
            end
            if (rd_q.size() != 0) begin
                $display("%s: read data came from a frame without a read", f_name[idx]);
                errors++;
                rd_q.delete();
            end
        end
        if (errors == errs_before) begin
            n_pass++;
            $display("test %s: pass", f_name[idx]);
        end else begin
            n_fail++;
            $display("test %s: fail", f_name[idx]);
        end
    endtask

    initial begin
        rst      = 1'b1;
        fire     = 1'b0;
        din      = 4'h0;
        seed     = 32'h031c_5002;
        errors   = 0;
        n_pass   = 0;
        n_fail   = 0;
        n_frames = 0;
        for (i = 0; i < (1 << `NIB_REG_AW); i++) model_regs[i] = 8'h00;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        for (i = 0; i < n_frames; i++) run_frame(i);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_frames, n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
